// File: design/dir_arbiter.sv
/*
 * Grants one queue per cycle onto the directory access channel.
 * Writes win outright, the two lookup queues alternate in round robin.
 */
`timescale 1ns/1ps
`include "dir_macros.svh"

module dir_arbiter (
   input  logic                rclk,
   input  logic                rst_n,
   input  dir_pkg::dir_wr_req_t wr_head,
   input  logic                wr_not_empty,
   input  dir_pkg::dir_rd_req_t rd0_head,
   input  logic                rd0_not_empty,
   input  dir_pkg::dir_rd_req_t rd1_head,
   input  logic                rd1_not_empty,
   output logic                wr_pop,
   output logic                rd0_pop,
   output logic                rd1_pop,
   dir_mem_if.arb              mem
);

   // High when port 1 had the last lookup grant
   logic last_rd1;
   logic rd_any;
   logic wr_par;

   // Fixed priority for writes
   assign wr_pop  = wr_not_empty;
   // Port 0 goes when alone or when port 1 went last
   assign rd0_pop = !wr_not_empty && rd0_not_empty && (!rd1_not_empty || last_rd1);
   assign rd1_pop = !wr_not_empty && rd1_not_empty && (!rd0_not_empty || !last_rd1);
   assign rd_any  = rd0_pop || rd1_pop;

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         // Port 0 first out of reset
         last_rd1 <= 1'b1;
      end else if (rd_any) begin
         last_rd1 <= rd1_pop;
      end
   end

   // Even parity over the tag field, flipped on inject
   assign wr_par = (^wr_head.tag) ^ wr_head.inject;

   // Pop and grant are the same cycle
   assign mem.wr_en = wr_pop;
   assign mem.rd_en = rd_any;
   assign mem.wdata = {wr_par, wr_head.tag, wr_head.entry_vld};

   always_comb begin
      if (wr_pop) begin
         mem.index = wr_head.index;
      end else if (rd0_pop) begin
         mem.index = rd0_head.index;
      end else begin
         mem.index = rd1_head.index;
      end
   end

   // Port id only matters on reads
   assign mem.port = rd1_pop ? rd1_head.port : rd0_head.port;

endmodule

// File: design/dir_credit_fifo.sv
/*
 * Credit-managed request queue with a type-parameter payload.
 * Holds DIR_CREDITS entries and pulses credit in the cycle after each pop.
 */
`timescale 1ns/1ps
`include "dir_macros.svh"

module dir_credit_fifo #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     rclk,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     not_empty,
   output logic     credit
);

   localparam int DEPTH = `DIR_CREDITS;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         slots [DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_push;
   logic             do_pop;

   assign full      = (count == CNT_W'(DEPTH));
   assign not_empty = (count != '0);
   // A requester that obeys its credits never pushes into a full queue
   assign do_push   = push && !full;
   assign do_pop    = pop && not_empty;
   assign head      = slots[rd_ptr];

   // Storage, written at the tail
   always_ff @(posedge rclk) begin
      if (do_push) begin
         slots[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         // Wrap explicitly so any depth works
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
         // One credit back per entry that leaves
         credit <= do_pop;
      end
   end

endmodule

// File: design/dir_macros.svh
/*
 * Width, depth and credit constants for the L2 tag directory slice.
 * Include in every RTL file that sizes a port, a field or a queue.
 */
`ifndef DIR_MACROS_SVH
`define DIR_MACROS_SVH

// Entry layout {parity, tag, valid}
`define DIR_WORD_W   32
`define DIR_TAG_W    30

// Index is {panel, offset}, panel 0 is top and 1 is bottom
`define DIR_IDX_W    6
`define DIR_OFF_W    5
`define DIR_DEPTH    32

// Queue depth and starting credits per requester
`define DIR_CREDITS  4

`endif

// File: design/dir_mem_if.sv
/*
 * Access channel from the arbiter to the panel array.
 * One granted read or write per cycle, valid only in the grant cycle.
 */
`timescale 1ns/1ps
`include "dir_macros.svh"

interface dir_mem_if;

   // Read and write strobes, never both high
   logic                   rd_en;
   logic                   wr_en;
   // Full index, top bit picks the panel
   logic [`DIR_IDX_W-1:0]  index;
   // Encoded entry with parity, used on writes only
   logic [`DIR_WORD_W-1:0] wdata;
   // Requester of a read, carried to the response
   dir_pkg::dir_port_t     port;

   modport arb (
      output rd_en, wr_en, index, wdata, port
   );

   modport mem (
      input  rd_en, wr_en, index, wdata, port
   );

endinterface

// File: design/dir_out_check.sv
/*
 * Picks the addressed panel word and checks its parity.
 * Registers the lookup response together with the parity error flag.
 */
`timescale 1ns/1ps
`include "dir_macros.svh"

module dir_out_check (
   input  logic             rclk,
   input  logic             rst_n,
   dir_rd_if.check          rd,
   output dir_pkg::dir_rsp_t rsp,
   output logic             rsp_valid
);

   logic [`DIR_WORD_W-1:0] word;
   // Even and odd bit rows, 16 wide each
   logic [15:0]            row1_bits;
   logic [15:0]            row2_bits;
   logic                   row1_parity;
   logic                   row2_parity;
   logic                   perr_next;

   // Top when selected, bottom otherwise
   assign word = rd.sel_top ? rd.top_data : rd.bottom_data;

   // Row 1 is bits 30..2 padded with a zero, row 2 is bits 31..1
   always_comb begin
      row1_bits[15] = 1'b0;
      for (int i = 0; i < 15; i++) begin
         row1_bits[i] = word[2*i+2];
      end
      for (int i = 0; i < 16; i++) begin
         row2_bits[i] = word[2*i+1];
      end
   end

   assign row1_parity = ^row1_bits;
   assign row2_parity = ^row2_bits;

   // Only a valid entry on a live read can flag an error
   assign perr_next = (row1_parity ^ row2_parity) && word[0]
                      && (rd.sel_top || rd.sel_bottom);

   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         rsp       <= '0;
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= rd.valid;
         if (rd.valid) begin
            rsp.port      <= rd.port;
            rsp.tag       <= word[`DIR_TAG_W:1];
            rsp.entry_vld <= word[0];
            rsp.perr      <= perr_next;
         end
      end
   end

endmodule

// File: design/dir_panel_array.sv
/*
 * Top and bottom directory panels, 32 entries each.
 * Writes land in one panel at the grant edge, reads register both panels.
 */
`timescale 1ns/1ps
`include "dir_macros.svh"

module dir_panel_array (
   input  logic    rclk,
   input  logic    rst_n,
   dir_mem_if.mem  mem,
   dir_rd_if.array rd
);

   logic [`DIR_WORD_W-1:0] top_panel    [`DIR_DEPTH];
   logic [`DIR_WORD_W-1:0] bottom_panel [`DIR_DEPTH];

   logic [`DIR_OFF_W-1:0]  offset;
   logic                   panel_bottom;

   logic [`DIR_WORD_W-1:0] top_q;
   logic [`DIR_WORD_W-1:0] bottom_q;
   logic                   sel_top_q;
   logic                   sel_bottom_q;
   dir_pkg::dir_port_t     port_q;
   logic                   valid_q;

   // Index split into panel bit and row offset
   assign offset       = mem.index[`DIR_OFF_W-1:0];
   assign panel_bottom = mem.index[`DIR_IDX_W-1];

   // Only the addressed panel takes the write
   always_ff @(posedge rclk) begin
      if (mem.wr_en && !panel_bottom) begin
         top_panel[offset] <= mem.wdata;
      end
      if (mem.wr_en && panel_bottom) begin
         bottom_panel[offset] <= mem.wdata;
      end
   end

   // Read stage, both panels at the same offset
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         top_q        <= '0;
         bottom_q     <= '0;
         sel_top_q    <= 1'b0;
         sel_bottom_q <= 1'b0;
         port_q       <= 1'b0;
         valid_q      <= 1'b0;
      end else begin
         if (mem.rd_en) begin
            top_q    <= top_panel[offset];
            bottom_q <= bottom_panel[offset];
            port_q   <= mem.port;
         end
         // Selects drop back low when no read follows
         sel_top_q    <= mem.rd_en && !panel_bottom;
         sel_bottom_q <= mem.rd_en && panel_bottom;
         valid_q      <= mem.rd_en;
      end
   end

   assign rd.top_data    = top_q;
   assign rd.bottom_data = bottom_q;
   assign rd.sel_top     = sel_top_q;
   assign rd.sel_bottom  = sel_bottom_q;
   assign rd.port        = port_q;
   assign rd.valid       = valid_q;

endmodule

// File: design/dir_pkg.sv
/*
 * Request, write and response types shared by the directory slice.
 * Referenced by scoped name from the queues, arbiter, array and checker.
 */
`include "dir_macros.svh"

package dir_pkg;

   // Lookup requester id, 0 or 1
   typedef logic dir_port_t;

   // Lookup request, about 7 bits
   typedef struct packed {
      logic [`DIR_IDX_W-1:0] index;
      dir_port_t             port;
   } dir_rd_req_t;

   // Fill or write request, about 38 bits
   typedef struct packed {
      logic [`DIR_IDX_W-1:0] index;
      logic [`DIR_TAG_W-1:0] tag;
      logic                  entry_vld;
      // Store flipped parity to exercise the error path
      logic                  inject;
   } dir_wr_req_t;

   // Lookup response as registered by the checker
   typedef struct packed {
      dir_port_t             port;
      logic [`DIR_TAG_W-1:0] tag;
      logic                  entry_vld;
      // Row parity mismatch on a valid entry
      logic                  perr;
   } dir_rsp_t;

endpackage

// File: design/dir_rd_if.sv
/*
 * Read channel from the panel array to the output checker.
 * Carries both panel words and one-hot selects one cycle after a grant.
 */
`timescale 1ns/1ps
`include "dir_macros.svh"

interface dir_rd_if;

   // Same offset read from both panels
   logic [`DIR_WORD_W-1:0] top_data;
   logic [`DIR_WORD_W-1:0] bottom_data;
   // One-hot panel select, both low when idle
   logic                   sel_top;
   logic                   sel_bottom;
   // Requester of this read
   dir_pkg::dir_port_t     port;
   logic                   valid;

   modport array (
      output top_data, bottom_data, sel_top, sel_bottom, port, valid
   );

   modport check (
      input  top_data, bottom_data, sel_top, sel_bottom, port, valid
   );

endinterface

// File: design/dir_subsys_top.sv
/*
 * Tag directory slice top, three credit queues feeding one arbiter.
 * Lookups return on the rsp_* ports two cycles after their grant.
 */
`timescale 1ns/1ps
`include "dir_macros.svh"

module dir_subsys_top (
   input  logic                  rclk,
   input  logic                  rst_n,
   // Lookup port 0
   input  logic                  rd0_valid,
   input  logic [`DIR_IDX_W-1:0] rd0_index,
   output logic                  rd0_credit,
   // Lookup port 1
   input  logic                  rd1_valid,
   input  logic [`DIR_IDX_W-1:0] rd1_index,
   output logic                  rd1_credit,
   // Fill and write port
   input  logic                  wr_valid,
   input  logic [`DIR_IDX_W-1:0] wr_index,
   input  logic [`DIR_TAG_W-1:0] wr_tag,
   input  logic                  wr_entry_vld,
   input  logic                  wr_inject,
   output logic                  wr_credit,
   // Lookup response
   output logic                  rsp_valid,
   output logic                  rsp_port,
   output logic [`DIR_TAG_W-1:0] rsp_tag,
   output logic                  rsp_entry_vld,
   output logic                  rsp_perr
);

   dir_pkg::dir_rd_req_t rd0_req;
   dir_pkg::dir_rd_req_t rd1_req;
   dir_pkg::dir_wr_req_t wr_req;

   dir_pkg::dir_rd_req_t rd0_head;
   dir_pkg::dir_rd_req_t rd1_head;
   dir_pkg::dir_wr_req_t wr_head;

   logic rd0_not_empty;
   logic rd1_not_empty;
   logic wr_not_empty;
   logic rd0_pop;
   logic rd1_pop;
   logic wr_pop;

   dir_pkg::dir_rsp_t rsp;

   dir_mem_if mem_ch ();
   dir_rd_if  rd_ch ();

   // Port id comes from the port the lookup entered on
   assign rd0_req.index = rd0_index;
   assign rd0_req.port  = 1'b0;
   assign rd1_req.index = rd1_index;
   assign rd1_req.port  = 1'b1;

   assign wr_req.index     = wr_index;
   assign wr_req.tag       = wr_tag;
   assign wr_req.entry_vld = wr_entry_vld;
   assign wr_req.inject    = wr_inject;

   dir_credit_fifo #(.payload_t(dir_pkg::dir_rd_req_t)) u_rd0_q (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .push      (rd0_valid),
      .push_data (rd0_req),
      .pop       (rd0_pop),
      .head      (rd0_head),
      .not_empty (rd0_not_empty),
      .credit    (rd0_credit)
   );

   dir_credit_fifo #(.payload_t(dir_pkg::dir_rd_req_t)) u_rd1_q (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .push      (rd1_valid),
      .push_data (rd1_req),
      .pop       (rd1_pop),
      .head      (rd1_head),
      .not_empty (rd1_not_empty),
      .credit    (rd1_credit)
   );

   dir_credit_fifo #(.payload_t(dir_pkg::dir_wr_req_t)) u_wr_q (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .push      (wr_valid),
      .push_data (wr_req),
      .pop       (wr_pop),
      .head      (wr_head),
      .not_empty (wr_not_empty),
      .credit    (wr_credit)
   );

   dir_arbiter u_arb (
      .rclk          (rclk),
      .rst_n         (rst_n),
      .wr_head       (wr_head),
      .wr_not_empty  (wr_not_empty),
      .rd0_head      (rd0_head),
      .rd0_not_empty (rd0_not_empty),
      .rd1_head      (rd1_head),
      .rd1_not_empty (rd1_not_empty),
      .wr_pop        (wr_pop),
      .rd0_pop       (rd0_pop),
      .rd1_pop       (rd1_pop),
      .mem           (mem_ch.arb)
   );

   dir_panel_array u_array (
      .rclk  (rclk),
      .rst_n (rst_n),
      .mem   (mem_ch.mem),
      .rd    (rd_ch.array)
   );

   dir_out_check u_check (
      .rclk      (rclk),
      .rst_n     (rst_n),
      .rd        (rd_ch.check),
      .rsp       (rsp),
      .rsp_valid (rsp_valid)
   );

   // Response struct broken out to plain ports
   assign rsp_port      = rsp.port;
   assign rsp_tag       = rsp.tag;
   assign rsp_entry_vld = rsp.entry_vld;
   assign rsp_perr      = rsp.perr;

endmodule

// File: project.f
+incdir+design
design/dir_pkg.sv
design/dir_mem_if.sv
design/dir_rd_if.sv
design/dir_credit_fifo.sv
design/dir_arbiter.sv
design/dir_panel_array.sv
design/dir_out_check.sv
design/dir_subsys_top.sv
test/tb_dir_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the directory slice testbench with Verilator
set -e
cd "$(dirname "$0")"

mkdir -p build
verilator --binary --timing --assert -f project.f \
   --top-module tb_dir_subsys --Mdir build/obj_dir -o tb_dir_subsys

./build/obj_dir/tb_dir_subsys | tee build/sim.log

if grep -q "TEST FAILED" build/sim.log || ! grep -q "TEST PASSED" build/sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation passed"

// File: test/tb_dir_subsys.sv
/*
 * Testbench for the tag directory slice. Fills both panels, reads them back
 * from both lookup ports against a model, and checks parity errors, credits and reset.
 */
`timescale 1ns/1ps
`include "dir_macros.svh"

module tb_dir_subsys;

   localparam int CLK_PERIOD  = 8;
   localparam int CREDITS     = `DIR_CREDITS;
   localparam int TAG_W       = `DIR_TAG_W;
   localparam int IDX_W       = `DIR_IDX_W;
   localparam int EXP_W       = TAG_W + 2;
   localparam int ENTRIES     = 2 * `DIR_DEPTH;
   localparam int INJ_WRITES  = 8;
   localparam int MIX_READS   = 32;
   localparam int MAX_LOOKUPS = 128;
   // Writes and lookups over all tests
   localparam int TOTAL_REQ   = 2 * ENTRIES + 2 * INJ_WRITES + 2 * MIX_READS;
   // Drain of three full queues at the same per-request budget as the watchdog
   localparam int IDLE_LIMIT  = 20 * 3 * CREDITS;

   logic             rclk;
   logic             rst_n;
   logic             rd0_valid, rd1_valid, wr_valid;
   logic [IDX_W-1:0] rd0_index, rd1_index, wr_index;
   logic [TAG_W-1:0] wr_tag;
   logic             wr_entry_vld, wr_inject;
   logic             rd0_credit, rd1_credit, wr_credit;
   logic             rsp_valid, rsp_port, rsp_entry_vld, rsp_perr;
   logic [TAG_W-1:0] rsp_tag;

   // Reference model of the 64 entries
   logic [TAG_W-1:0] model_tag  [ENTRIES];
   logic             model_vld  [ENTRIES];
   logic             model_perr [ENTRIES];

   // Expected {perr, vld, tag} per port in issue order
   logic [EXP_W-1:0] issued_exp [2][MAX_LOOKUPS];
   int               issue_cnt  [2] = '{default: 0};
   int               retire_cnt [2] = '{default: 0};
   // Requesters 0 and 1 are lookups, 2 is the write port
   int               spent      [3] = '{default: 0};
   int               returned   [3] = '{default: 0};
   int               plan0 [$];
   int               plan1 [$];

   int rsp_pass      = 0;
   int rsp_fail      = 0;
   int mon_fail      = 0;
   int reset_fail    = 0;
   int main_pass     = 0;
   int main_fail     = 0;
   int tests_run     = 0;
   int tests_failed  = 0;
   int errs_at_start = 0;

   dir_subsys_top dut0 (
      .rclk(rclk), .rst_n(rst_n),
      .rd0_valid(rd0_valid), .rd0_index(rd0_index), .rd0_credit(rd0_credit),
      .rd1_valid(rd1_valid), .rd1_index(rd1_index), .rd1_credit(rd1_credit),
      .wr_valid(wr_valid), .wr_index(wr_index), .wr_tag(wr_tag),
      .wr_entry_vld(wr_entry_vld), .wr_inject(wr_inject), .wr_credit(wr_credit),
      .rsp_valid(rsp_valid), .rsp_port(rsp_port), .rsp_tag(rsp_tag),
      .rsp_entry_vld(rsp_entry_vld), .rsp_perr(rsp_perr)
   );

   initial begin
      rclk = 1'b0;
      forever #(CLK_PERIOD / 2) rclk = ~rclk;
   end

   // Credit outputs and responses stay low while reset is held
   reset_quiet: assert property (@(posedge rclk)
      !rst_n |-> !(rsp_valid || rd0_credit || rd1_credit || wr_credit))
   else begin
      $display("t=%0t response or credit output active during reset", $time);
      reset_fail++;
   end

   function automatic bit compare_value(string name, logic [31:0] exp, logic [31:0] got);
      assert (got === exp)
      else $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
      return got === exp;
   endfunction

   function automatic int credits_left(int r);
      return CREDITS - spent[r] + returned[r];
   endfunction

   function automatic int total_errors();
      return rsp_fail + mon_fail + reset_fail + main_fail;
   endfunction

   function automatic bit is_idle();
      return credits_left(0) == CREDITS && credits_left(1) == CREDITS
             && credits_left(2) == CREDITS && retire_cnt[0] == issue_cnt[0]
             && retire_cnt[1] == issue_cnt[1];
   endfunction

   // Each credit pulse is counted at the rising edge that ends it
   always @(posedge rclk) begin
      logic [2:0] pulses;
      pulses = {wr_credit, rd1_credit, rd0_credit};
      for (int r = 0; r < 3; r++) begin
         if (pulses[r]) begin
            returned[r]++;
            if (returned[r] > spent[r]) begin
               $display("t=%0t credit pulse on requester %0d with nothing outstanding",
                        $time, r);
               mon_fail++;
            end
         end
      end
   end

   // Response checker, per-port order kept by the retire counters
   always @(negedge rclk) begin
      logic [EXP_W-1:0] exp;
      int               p;
      if (rst_n && rsp_valid) begin
         p = int'(rsp_port);
         if (retire_cnt[p] >= issue_cnt[p]) begin
            $display("t=%0t response on port %0d with no lookup outstanding", $time, p);
            rsp_fail++;
         end else begin
            exp = issued_exp[p][retire_cnt[p]];
            retire_cnt[p]++;
            if (compare_value("rsp_tag", 32'(exp[TAG_W-1:0]), 32'(rsp_tag))) rsp_pass++;
            else rsp_fail++;
            if (compare_value("rsp_entry_vld", 32'(exp[TAG_W]), 32'(rsp_entry_vld))) rsp_pass++;
            else rsp_fail++;
            if (compare_value("rsp_perr", 32'(exp[TAG_W+1]), 32'(rsp_perr))) rsp_pass++;
            else rsp_fail++;
         end
      end
   end

   // One write in the current cycle once a credit is held
   task automatic write_entry(int idx, logic [TAG_W-1:0] tag, logic vld, logic inj);
      while (credits_left(2) == 0) begin
         @(negedge rclk);
      end
      wr_valid     = 1'b1;
      wr_index     = IDX_W'(idx);
      wr_tag       = tag;
      wr_entry_vld = vld;
      wr_inject    = inj;
      spent[2]++;
      model_tag[idx]  = tag;
      model_vld[idx]  = vld;
      model_perr[idx] = inj && vld;
      @(negedge rclk);
      wr_valid = 1'b0;
   endtask

   task automatic record_lookup(int p, int idx);
      issued_exp[p][issue_cnt[p]] = {model_perr[idx], model_vld[idx], model_tag[idx]};
      issue_cnt[p]++;
      spent[p]++;
   endtask

   // Drains plan0 and plan1, each port sending whenever it holds a credit
   task automatic issue_lookups();
      while (plan0.size() > 0 || plan1.size() > 0) begin
         rd0_valid = 1'b0;
         rd1_valid = 1'b0;
         if (plan0.size() > 0 && credits_left(0) > 0) begin
            rd0_valid = 1'b1;
            rd0_index = IDX_W'(plan0[0]);
            record_lookup(0, plan0.pop_front());
         end
         if (plan1.size() > 0 && credits_left(1) > 0) begin
            rd1_valid = 1'b1;
            rd1_index = IDX_W'(plan1[0]);
            record_lookup(1, plan1.pop_front());
         end
         @(negedge rclk);
      end
      rd0_valid = 1'b0;
      rd1_valid = 1'b0;
   endtask

   // Idle means every credit is home and every lookup answered
   task automatic wait_idle();
      int waited;
      waited = 0;
      while (!is_idle() && waited < IDLE_LIMIT) begin
         @(negedge rclk);
         waited++;
      end
      if (retire_cnt[0] != issue_cnt[0] || retire_cnt[1] != issue_cnt[1]) begin
         $display("t=%0t lookups still unanswered after %0d cycles", $time, IDLE_LIMIT);
         mon_fail++;
      end
      repeat (2) @(negedge rclk);
   endtask

   task automatic finish_test(string name);
      tests_run++;
      if (total_errors() == errs_at_start) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         $display("test %0d %s: %0d errors", tests_run, name, total_errors() - errs_at_start);
         tests_failed++;
      end
      errs_at_start = total_errors();
   endtask

   initial begin
      int idle_events;
      void'($urandom(32'h8a62e38f));
      rst_n        = 1'b0;
      rd0_valid    = 1'b0;
      rd1_valid    = 1'b0;
      wr_valid     = 1'b0;
      rd0_index    = '0;
      rd1_index    = '0;
      wr_index     = '0;
      wr_tag       = '0;
      wr_entry_vld = 1'b0;
      wr_inject    = 1'b0;
      idle_events  = 0;

      // Reset for 8 cycles then a quiet window with no requests
      repeat (8) begin
         @(negedge rclk);
         if (rsp_valid || rd0_credit || rd1_credit || wr_credit) idle_events++;
      end
      rst_n = 1'b1;
      repeat (10) begin
         @(negedge rclk);
         if (rsp_valid || rd0_credit || rd1_credit || wr_credit) idle_events++;
      end
      if (compare_value("idle outputs", 0, idle_events)) main_pass++;
      else main_fail++;
      finish_test("reset and idle");

      // Fill both panels, no inject, then read all from port 0
      for (int i = 0; i < ENTRIES; i++) begin
         write_entry(i, TAG_W'($urandom()), 1'($urandom_range(1)), 1'b0);
      end
      wait_idle();
      for (int i = 0; i < ENTRIES; i++) begin
         plan0.push_back(i);
      end
      issue_lookups();
      wait_idle();
      finish_test("fill and read back");

      // Injected parity, alternating valid, spread over both panels
      for (int i = 0; i < INJ_WRITES; i++) begin
         write_entry(i * 8 + 3, TAG_W'($urandom()), 1'(i % 2), 1'b1);
      end
      wait_idle();
      for (int i = 0; i < INJ_WRITES; i++) begin
         plan1.push_back(i * 8 + 3);
      end
      issue_lookups();
      wait_idle();
      finish_test("parity inject");

      // Both lookup ports at full credit rate with random indices
      for (int i = 0; i < MIX_READS; i++) begin
         plan0.push_back($urandom_range(ENTRIES - 1));
         plan1.push_back($urandom_range(ENTRIES - 1));
      end
      issue_lookups();
      wait_idle();
      finish_test("dual port lookups");

      // All credits home, one pulse per accepted request
      for (int r = 0; r < 3; r++) begin
         if (compare_value($sformatf("credits of requester %0d", r), CREDITS, credits_left(r)))
            main_pass++;
         else main_fail++;
      end
      finish_test("credit accounting");

      $display("%0d tests run, %0d with errors, %0d checks passed, %0d failed",
               tests_run, tests_failed, rsp_pass + main_pass, total_errors());
      if (total_errors() == 0 && tests_failed == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog sized from the request count with a margin
   initial begin
      #(CLK_PERIOD * (TOTAL_REQ * 20 + 400));
      $display("watchdog expired before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

endmodule
